// ==== Makefile ====
# Verilator build and run of the cartridge support testbench
TOP := tb_sms_cart_support

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
+incdir+include
design/sms_pkg.sv
design/sms_download_if.sv
design/sms_clock_enables.sv
design/sms_cart_loader.sv
design/sms_cheat_loader.sv
design/sms_backup_sequencer.sv
design/sms_cart_support.sv
testbench/sms_cart_support_properties.sv
testbench/tb_sms_cart_support.sv

// ==== design/sms_backup_sequencer.sv ====
// Backup RAM sequencer for load, save, autosave and load after download
// Backup is only enabled when a writable image is mounted during a download
// Each transfer moves all sectors in order through the SD request handshake
`timescale 1ns/10ps
`include "sms_consts.svh"

module sms_backup_sequencer import sms_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        cart_busy,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic        load_req,
	input  logic        save_req,
	input  logic        autosave_en,
	input  logic        osd_open,
	input  logic        nvram_we,
	output sector_t     sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	input  logic        sd_ack,
	output logic        backup_busy,
	output logic        backup_loading,
	output logic        core_hold,
	output logic        led_user
);

	logic bk_ena;
	logic bk_pending;
	logic cart_q;
	logic load_q;
	logic save_q;
	logic ack_q;
	logic save_any;
	logic load_trig;
	logic save_trig;
	logic dl_done;
	logic start;
	logic start_load;

	// Autosave fires once the OSD is opened
	assign save_any   = save_req | (bk_pending & autosave_en & osd_open);
	assign load_trig  = load_req & bk_ena & ~load_q;
	assign save_trig  = save_any & bk_ena & ~save_q;
	assign dl_done    = cart_q & ~cart_busy & (|img_size) & bk_ena;
	assign start      = ~backup_busy & (load_trig | save_trig | dl_done);
	assign start_load = dl_done | load_trig; // Load wins over save

	// ====================
	// Enable and pending flag
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
			cart_q     <= 1'b0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			cart_q <= cart_busy;
			load_q <= load_req & bk_ena;
			save_q <= save_any & bk_ena;
			ack_q  <= sd_ack;
			if (!cart_q && cart_busy)
				bk_ena <= 1'b0;
			if (cart_busy && img_mounted && !img_readonly)
				bk_ena <= 1'b1; // Save file mounts while the cart loads
			if (start)
				bk_pending <= 1'b0;
			else if (bk_ena && !osd_open && nvram_we)
				bk_pending <= 1'b1;
		end
	end

	// ====================
	// Sector transfers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sd_lba         <= '0;
			sd_rd          <= 1'b0;
			sd_wr          <= 1'b0;
			backup_busy    <= 1'b0;
			backup_loading <= 1'b0;
		end else begin
			if (!ack_q && sd_ack) begin
				sd_rd <= 1'b0; // Request accepted
				sd_wr <= 1'b0;
			end
			if (!backup_busy) begin
				if (start) begin
					backup_busy    <= 1'b1;
					backup_loading <= start_load;
					sd_lba         <= '0;
					sd_rd          <= start_load;
					sd_wr          <= ~start_load;
				end
			end else if (ack_q && !sd_ack) begin
				if (sd_lba == sector_t'(`SMS_BACKUP_SECTORS - 1)) begin
					backup_busy    <= 1'b0;
					backup_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= backup_loading;
					sd_wr  <= ~backup_loading;
				end
			end
		end
	end

	assign core_hold = cart_busy | backup_loading;
	assign led_user  = cart_busy | backup_busy | (autosave_en & bk_pending);

endmodule

// ==== design/sms_cart_loader.sv ====
// Cartridge download writer and read address translation
// The host must hold off the next byte while ioctl_wait is high
// The header flag assumes addr points one past the last byte when download drops
// Data bytes go from the host bus straight to the ROM memory
`timescale 1ns/10ps
`include "sms_consts.svh"

module sms_cart_loader import sms_pkg::*; (
	input  logic             clk_sys,
	input  logic             rst_n,
	sms_download_if.listen   dl,
	output logic             ioctl_wait,
	output logic             rom_wr,     // Toggles once per byte
	input  logic             rom_wr_ack, // Equals rom_wr when the byte is stored
	output logic [23:0]      rom_waddr,
	input  rom_addr_t        rom_raddr_in,
	output rom_addr_t        rom_raddr_out,
	output logic             cart_busy,
	output logic             game_gear
);

	logic      cart_dl;
	logic      cart_dl_q;
	logic      has_header;
	rom_addr_t cart_mask;
	rom_addr_t hdr_mask; // Mask of addresses with the header removed

	assign cart_dl   = dl.download & ~&dl.index;
	assign cart_busy = cart_dl;

	// ====================
	// Write handshake
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_dl_q  <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr     <= 1'b0;
			rom_waddr  <= '0;
			has_header <= 1'b0;
			game_gear  <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (!cart_dl_q && cart_dl) begin
				rom_waddr <= '0; // New file starts at the bottom
			end else if (dl.wr && cart_dl) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;
				game_gear  <= dl.index[4:0] == 5'(`SMS_CART_INDEX);
			end else if (ioctl_wait && (rom_wr == rom_wr_ack)) begin
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + 24'd1;
			end
			if (cart_dl_q && !cart_dl)
				has_header <= dl.addr[9]; // Size is 512 past a power of two
		end
	end

	// ====================
	// Size masks
	// ====================
	always_ff @(posedge clk_sys) begin
		if (dl.wr && cart_dl) begin
			cart_mask <= cart_mask | dl.addr[21:0];
			hdr_mask  <= hdr_mask | (dl.addr[21:0] - 22'(`SMS_HEADER_BYTES));
			if (dl.addr == '0)
				cart_mask <= '0;
			if (dl.addr == 25'(`SMS_HEADER_BYTES))
				hdr_mask <= '0; // First byte after the header
		end
	end

	// Skip the header, then wrap to the image size
	assign rom_raddr_out = has_header ?
		(rom_raddr_in + rom_addr_t'(`SMS_HEADER_BYTES)) & hdr_mask :
		rom_raddr_in & cart_mask;

endmodule

// ==== design/sms_cart_support.sv ====
// Cartridge support top level
// Status bits arrive as plain inputs; the host bus drives the download interface
// ROM data goes from ioctl_dout to memory outside this block
`timescale 1ns/10ps

module sms_cart_support import sms_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	// Host download bus
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic        ioctl_wait,
	// Clock enables
	output logic        ce_cpu,
	output logic        ce_vdp,
	output logic        ce_pix,
	output logic        ce_sp,
	// ROM memory
	output logic        rom_wr,
	input  logic        rom_wr_ack,
	output logic [23:0] rom_waddr,
	input  rom_addr_t   rom_raddr_in,
	output rom_addr_t   rom_raddr_out,
	output logic        cart_busy,
	output logic        game_gear,
	// Cheats
	output logic [31:0] cheat_flags,
	output logic [31:0] cheat_address,
	output logic [31:0] cheat_compare,
	output logic [31:0] cheat_replace,
	output logic        cheat_valid,
	// Backup RAM and SD image
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic        load_req,
	input  logic        save_req,
	input  logic        autosave_en,
	input  logic        osd_open,
	input  logic        nvram_we,
	output sector_t     sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	input  logic        sd_ack,
	output logic        backup_busy,
	output logic        backup_loading,
	output logic        core_hold,
	output logic        led_user
);

	sms_download_if dl ();
	cheat_code_t    cheat_code;

	// Source side of the download bus
	assign dl.download = ioctl_download;
	assign dl.index    = ioctl_index;
	assign dl.wr       = ioctl_wr;
	assign dl.addr     = ioctl_addr;
	assign dl.dout     = ioctl_dout;

	sms_clock_enables u_enables (.*);

	sms_cart_loader u_cart (.dl(dl.listen), .*);

	sms_cheat_loader u_cheat (.dl(dl.listen), .*);

	sms_backup_sequencer u_backup (.*);

	assign cheat_flags   = cheat_code.flags;
	assign cheat_address = cheat_code.address;
	assign cheat_compare = cheat_code.compare;
	assign cheat_replace = cheat_code.replace;

endmodule

// ==== design/sms_cheat_loader.sv ====
// Cheat record assembler
// Each 16-byte record holds flags, address, compare and replace words
// Words arrive least significant byte first
`timescale 1ns/10ps
`include "sms_consts.svh"

module sms_cheat_loader import sms_pkg::*; (
	input  logic           clk_sys,
	input  logic           rst_n,
	sms_download_if.listen dl,
	output cheat_code_t    cheat_code,
	output logic           cheat_valid // One pulse per complete record
);

	localparam int IDX_W = $clog2(`SMS_CHEAT_BYTES);

	logic             cheat_wr;
	logic [IDX_W-1:0] byte_sel;
	logic [4:0]       lane; // Bit offset of the byte in its word

	assign cheat_wr = dl.download & (&dl.index) & dl.wr;
	assign byte_sel = dl.addr[IDX_W-1:0];
	assign lane     = {byte_sel[1:0], 3'b000};

	// Byte n goes to word n/4 at byte n%4
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (byte_sel[IDX_W-1:2])
				2'd0: cheat_code.flags[lane +: 8]   <= dl.dout;
				2'd1: cheat_code.address[lane +: 8] <= dl.dout;
				2'd2: cheat_code.compare[lane +: 8] <= dl.dout;
				default: cheat_code.replace[lane +: 8] <= dl.dout;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= cheat_wr && (byte_sel == IDX_W'(`SMS_CHEAT_BYTES - 1));
		end
	end

endmodule

// ==== design/sms_clock_enables.sv ====
// Clock enables for CPU, VDP, pixel and sound from one phase counter
// Enables are one-cycle pulses decoded from the counter, all on clk_sys
// Pattern repeats every SMS_CE_PERIOD cycles
`timescale 1ns/10ps
`include "sms_consts.svh"

module sms_clock_enables (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_cpu, // Clock / 15
	output logic ce_vdp, // Clock / 5
	output logic ce_pix, // Clock / 10
	output logic ce_sp   // Clock / 2
);

	localparam int PHASE_W = $clog2(`SMS_CE_PERIOD);

	logic [PHASE_W-1:0] phase;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (phase == PHASE_W'(`SMS_CE_PERIOD - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Fixed decode of the 30-phase pattern
	always_comb begin
		ce_vdp = 1'b0;
		ce_pix = 1'b0;
		ce_cpu = 1'b0;
		ce_sp  = phase[0]; // Every odd phase
		case (phase)
			PHASE_W'(4), PHASE_W'(14): ce_vdp = 1'b1;
			PHASE_W'(9): begin
				ce_vdp = 1'b1;
				ce_pix = 1'b1;
				ce_cpu = 1'b1;
			end
			PHASE_W'(19), PHASE_W'(29): begin
				ce_vdp = 1'b1;
				ce_pix = 1'b1;
			end
			PHASE_W'(24): begin
				ce_vdp = 1'b1;
				ce_cpu = 1'b1; // Late CPU phase keeps the H counter test happy
			end
			default: ;
		endcase
	end

endmodule

// ==== design/sms_download_if.sv ====
// Host download bus as seen by the loaders
// A byte is valid only in the cycle in which wr is high
// Index all ones marks a cheat file, anything else a cartridge
`timescale 1ns/10ps

interface sms_download_if;
	logic        download; // High for the whole file transfer
	logic [7:0]  index;    // File type selector
	logic        wr;
	logic [24:0] addr;     // Byte offset within the file
	logic [7:0]  dout;

	modport source (output download, output index, output wr, output addr, output dout);

	modport listen (input download, input index, input wr, input addr, input dout);
endinterface

// ==== design/sms_pkg.sv ====
// Shared types of the cartridge support logic
// ROM addresses cover 4 MiB of cartridge space
// The sector number width follows the backup sector count
`include "sms_consts.svh"

package sms_pkg;

	// ====================
	// Cartridge memory
	// ====================
	typedef logic [21:0] rom_addr_t; // Byte address into the cartridge

	// ====================
	// Backup RAM
	// ====================
	typedef logic [$clog2(`SMS_BACKUP_SECTORS)-1:0] sector_t;

	// ====================
	// Cheat codes
	// ====================
	// Field order matches the byte order of a downloaded record
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare; // Value expected at the address
		logic [31:0] replace; // Value returned instead
	} cheat_code_t;

endpackage

// ==== include/sms_consts.svh ====
// Fixed constants of the cartridge support logic
// The sector count must stay a power of two, since the sector number wraps
// Cheat records are fixed at 16 bytes, and the loader decodes four 32-bit words
`ifndef SMS_CONSTS_SVH
`define SMS_CONSTS_SVH

// ====================
// Clock enables
// ====================
`define SMS_CE_PERIOD 30 // Phases per enable pattern

// ====================
// Cartridge download
// ====================
`define SMS_HEADER_BYTES 512 // Copier header in front of some dumps
`define SMS_CART_INDEX 2 // Low index bits of a Game Gear file

// ====================
// Backup RAM and cheats
// ====================
`define SMS_BACKUP_SECTORS 64 // 512-byte sectors, 32 KiB total
`define SMS_CHEAT_BYTES 16 // One cheat record

`endif

// ==== testbench/sms_cart_support_properties.sv ====
// Concurrent checks on the cartridge support top level
// Bound into the DUT, every failed property adds to fail_count
`timescale 1ns/10ps

module sms_cart_support_properties (
	input logic clk_sys,
	input logic rst_n,
	input logic ce_cpu,
	input logic ce_vdp,
	input logic ce_pix,
	input logic ce_sp,
	input logic ioctl_wr,
	input logic ioctl_wait,
	input logic cart_busy,
	input logic rom_wr,
	input logic sd_rd,
	input logic sd_wr
);

	int fail_count = 0;

	// ====================
	// Clock enables
	// ====================
	enables_nested: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ce_cpu || ce_pix) |-> ce_vdp)
	else begin
		$error("ce_cpu or ce_pix pulsed without ce_vdp");
		fail_count++;
	end

	sound_alternates: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_sp |=> !ce_sp)
	else begin
		$error("ce_sp high on two cycles in a row");
		fail_count++;
	end

	// ====================
	// Cartridge and SD handshakes
	// ====================
	wait_after_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ioctl_wr && cart_busy) |=> ioctl_wait)
	else begin
		$error("ioctl_wait did not rise after a cartridge write strobe");
		fail_count++;
	end

	rom_wr_on_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(rom_wr != $past(rom_wr)) |-> $past(ioctl_wr && cart_busy))
	else begin
		$error("rom_wr toggled without a cartridge write strobe");
		fail_count++;
	end

	sd_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(sd_rd && sd_wr))
	else begin
		$error("sd_rd and sd_wr high together");
		fail_count++;
	end

endmodule

// ==== testbench/tb_sms_cart_support.sv ====
// Testbench for the cartridge support top level
// ROM and SD models answer their handshakes after random delays
// A cartridge download ends with addr one past the last byte
`timescale 1ns/10ps
`include "sms_consts.svh"

module tb_sms_cart_support import sms_pkg::*; ();

	logic        clk_sys;
	logic        rst_n;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        ioctl_wait;
	logic        ce_cpu;
	logic        ce_vdp;
	logic        ce_pix;
	logic        ce_sp;
	logic        rom_wr;
	logic        rom_wr_ack;
	logic [23:0] rom_waddr;
	rom_addr_t   rom_raddr_in;
	rom_addr_t   rom_raddr_out;
	logic        cart_busy;
	logic        game_gear;
	logic [31:0] cheat_flags;
	logic [31:0] cheat_address;
	logic [31:0] cheat_compare;
	logic [31:0] cheat_replace;
	logic        cheat_valid;
	logic        img_mounted;
	logic        img_readonly;
	logic [63:0] img_size;
	logic        load_req;
	logic        save_req;
	logic        autosave_en;
	logic        osd_open;
	logic        nvram_we;
	sector_t     sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        sd_ack;
	logic        backup_busy;
	logic        backup_loading;
	logic        core_hold;
	logic        led_user;

	integer     seed;
	int         errors;
	int         sd_faults;    // Mismatches seen by the SD model
	int         sd_count;     // Sectors requested in the current transfer
	int         cheat_pulses;
	int         test_num;
	int         test_base;
	bit         exp_load;     // Direction the SD model expects
	logic [7:0] cheat_bytes [`SMS_CHEAT_BYTES];

	sms_cart_support UUT (.*);

	bind sms_cart_support sms_cart_support_properties u_props (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	always @(negedge clk_sys) begin
		if (cheat_valid)
			cheat_pulses++;
	end

	// ====================
	// Memory models
	// ====================
	initial begin : rom_model
		int delay;
		rom_wr_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rom_wr != rom_wr_ack) begin
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(negedge clk_sys);
				rom_wr_ack = rom_wr; // Byte stored
			end
		end
	end

	initial begin : sd_model
		int delay;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(negedge clk_sys);
				assert (sd_lba == sector_t'(sd_count)) else begin
					$display("FAILED sd_lba: got %h, expected %h", sd_lba, sector_t'(sd_count));
					sd_faults++;
				end
				assert ({sd_rd, sd_wr} == {exp_load, !exp_load}) else begin
					$display("FAILED {sd_rd, sd_wr}: got %h, expected %h",
						{sd_rd, sd_wr}, {exp_load, !exp_load});
					sd_faults++;
				end
				sd_ack = 1'b1;
				sd_count++;
				delay = 2 + $unsigned($random(seed)) % 4; // Request must drop first
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	// ====================
	// Helpers
	// ====================
	function automatic int total_errors();
		return errors + sd_faults + UUT.u_props.fail_count;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		errors++;
	endtask

	task automatic end_test(input string name);
		$display("Test %0d %s: %0d errors", test_num, name, total_errors() - test_base);
		test_num++;
		test_base = total_errors();
	endtask

	// Cheat word w from bytes 4w..4w+3, low byte first
	function automatic logic [31:0] record_word(input int w);
		return {cheat_bytes[4*w+3], cheat_bytes[4*w+2], cheat_bytes[4*w+1], cheat_bytes[4*w]};
	endfunction

	task automatic send_cart(input logic [7:0] index, input int nbytes, input bit mount);
		logic prev_wr;
		int   t;
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		if (mount) begin
			@(negedge clk_sys);
			img_mounted = 1'b1;
			@(negedge clk_sys);
			img_mounted = 1'b0;
		end
		for (int a = 0; a < nbytes; a++) begin
			@(negedge clk_sys);
			check_value("rom_waddr", rom_waddr, a);
			check_value("cart_busy", cart_busy, 1);
			prev_wr    = rom_wr;
			ioctl_addr = 25'(a);
			ioctl_dout = 8'(a ^ (a >> 8));
			ioctl_wr   = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			t = 0;
			while (ioctl_wait && t < 50) begin
				@(negedge clk_sys);
				t++;
			end
			if (ioctl_wait)
				report_timeout("ioctl_wait to fall");
			check_value("rom_wr", rom_wr, !prev_wr);
		end
		check_value("rom_waddr", rom_waddr, nbytes);
		@(negedge clk_sys);
		ioctl_addr     = 25'(nbytes); // One past the last byte
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_value("cart_busy", cart_busy, 0);
	endtask

	task automatic check_translation(input int offset);
		rom_addr_t a;
		for (int i = 0; i < 8; i++) begin
			a = rom_addr_t'($random(seed));
			@(negedge clk_sys);
			rom_raddr_in = a;
			#2;
			check_value("rom_raddr_out", rom_raddr_out, (int'(a) + offset) & 16383);
		end
	endtask

	task automatic run_backup(input bit loading);
		int t;
		t = 0;
		while (!backup_busy && t < 20) begin
			@(negedge clk_sys);
			t++;
		end
		if (!backup_busy)
			report_timeout("a backup transfer to start");
		t = 0;
		while (backup_busy && t < 2000) begin
			check_value("backup_loading", backup_loading, loading);
			check_value("core_hold", core_hold, loading);
			@(negedge clk_sys);
			t++;
		end
		if (backup_busy)
			report_timeout("the backup transfer to end");
		check_value("backup_loading", backup_loading, 0);
		check_value("sector count", sd_count, `SMS_BACKUP_SECTORS);
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		int n_vdp;
		int n_pix;
		int n_cpu;
		int n_sp;
		int pulses_before;
		seed           = 32'hd8a9;
		errors         = 0;
		sd_faults      = 0;
		sd_count       = 0;
		cheat_pulses   = 0;
		test_num       = 1;
		test_base      = 0;
		exp_load       = 1'b1;
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_raddr_in   = '0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		load_req       = 1'b0;
		save_req       = 1'b0;
		autosave_en    = 1'b0;
		osd_open       = 1'b0;
		nvram_we       = 1'b0;
		repeat (10) @(negedge clk_sys);
		rst_n = 1'b1;

		// Any 30-cycle window holds one full pattern
		repeat (3 + $unsigned($random(seed)) % 30) @(negedge clk_sys);
		n_vdp = 0;
		n_pix = 0;
		n_cpu = 0;
		n_sp  = 0;
		repeat (`SMS_CE_PERIOD) begin
			@(negedge clk_sys);
			n_vdp += int'(ce_vdp);
			n_pix += int'(ce_pix);
			n_cpu += int'(ce_cpu);
			n_sp  += int'(ce_sp);
		end
		check_value("ce_vdp pulses", n_vdp, 6);
		check_value("ce_pix pulses", n_pix, 3);
		check_value("ce_cpu pulses", n_cpu, 2);
		check_value("ce_sp pulses", n_sp, 15);
		end_test("clock enables");

		send_cart(8'h02, 16384, 1'b0); // Game Gear file
		check_value("game_gear", game_gear, 1);
		end_test("cartridge writes");

		check_translation(0);
		send_cart(8'h01, 16384 + `SMS_HEADER_BYTES, 1'b0);
		check_value("game_gear", game_gear, 0);
		check_translation(`SMS_HEADER_BYTES);
		end_test("size masks");

		for (int i = 0; i < `SMS_CHEAT_BYTES; i++)
			cheat_bytes[i] = 8'($random(seed));
		pulses_before = cheat_pulses;
		@(negedge clk_sys);
		ioctl_index    = 8'hff;
		ioctl_download = 1'b1;
		for (int i = 0; i < `SMS_CHEAT_BYTES; i++) begin
			@(negedge clk_sys);
			ioctl_addr = 25'(i);
			ioctl_dout = cheat_bytes[i];
			ioctl_wr   = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
		end
		repeat (3) @(negedge clk_sys);
		ioctl_download = 1'b0;
		check_value("cheat_flags", cheat_flags, record_word(0));
		check_value("cheat_address", cheat_address, record_word(1));
		check_value("cheat_compare", cheat_compare, record_word(2));
		check_value("cheat_replace", cheat_replace, record_word(3));
		check_value("cheat_valid pulses", cheat_pulses - pulses_before, 1);
		end_test("cheat record");

		// Writable image mounted during the download
		img_size = 64'd32768;
		exp_load = 1'b1;
		sd_count = 0;
		send_cart(8'h01, 64, 1'b1);
		run_backup(1'b1);
		end_test("backup load");

		exp_load    = 1'b0;
		sd_count    = 0;
		autosave_en = 1'b1;
		nvram_we    = 1'b1;
		@(negedge clk_sys);
		nvram_we = 1'b0;
		@(negedge clk_sys);
		check_value("led_user", led_user, 1);
		osd_open = 1'b1; // Autosave on OSD open
		run_backup(1'b0);
		osd_open = 1'b0;
		check_value("led_user", led_user, 0);
		end_test("autosave");

		$display("Summary: %0d tests, %0d errors", test_num - 1, total_errors());
		if (total_errors() == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
